/* bench/clock_module_asserts.sv */
`timescale 1ns/100ps

module clock_module_asserts (
    input logic clk,
    input logic reset_p,
    input logic [3:0] com,
    input logic led_cookstart,
    input logic led_alarm,
    input logic buzz
);

    // Exactly one digit enabled, active low
    com_one_digit: assert property (@(posedge clk) disable iff (reset_p) $onehot(~com))
        else $error("com is %b, not exactly one enabled digit", com);

    buzz_follows_alarm: assert property (@(posedge clk) disable iff (reset_p)
        buzz == led_alarm)
        else $error("buzz %b differs from led_alarm %b", buzz, led_alarm);

    // Timer stops in the same cycle the alarm rises
    alarm_not_running: assert property (@(posedge clk) disable iff (reset_p)
        !(led_alarm && led_cookstart))
        else $error("led_alarm and led_cookstart both high");

endmodule

bind clock_module clock_module_asserts asserts_i (
    .clk(clk),
    .reset_p(reset_p),
    .com(com),
    .led_cookstart(led_cookstart),
    .led_alarm(led_alarm),
    .buzz(buzz)
);

/* bench/clock_module_tb.sv */
`timescale 1ns/100ps

module clock_module_tb;
    import clock_pkg::*;

    localparam int debounce_clks = 4;
    localparam int clks_per_centi = 3;
    localparam int scan_clks = 2;
    localparam int sec_clks = clks_per_centi * 100;
    localparam int frame_clks = 20;
    localparam int settle_frames = 6;
    localparam int num_steps = 17;
    localparam int key_none = -1;
    localparam int key_mode = 5;

    // What a step checks after its presses and wait
    localparam int chk_none = 0;
    localparam int chk_leds = 1;
    localparam int chk_range = 2;
    localparam int chk_mark = 3;
    localparam int chk_hold = 4;
    localparam int chk_alarm = 5;
    localparam int chk_later = 6;

    // LEDs as {stopwatch, cookstart, lap, alarm, buzz}
    typedef struct {
        int key;
        int presses;
        int wait_sec;
        int kind;
        display_word_u lo;
        display_word_u hi;
        logic [4:0] leds;
    } step_t;

    logic clk;
    logic reset_p;
    logic btn_mode;
    logic [4:0] btn;
    logic [7:0] seg_7;
    logic [3:0] com;
    logic led_stopwatch;
    logic led_cookstart;
    logic led_lap;
    logic led_alarm;
    logic buzz;

    int checks;
    int value_errors;
    int timeouts;
    display_word_u last_watch;
    step_t steps[num_steps];

    clock_module #(
        .debounce_clks(debounce_clks),
        .clks_per_centi(clks_per_centi),
        .scan_clks(scan_clks)
    ) dut_i (
        .clk(clk), .reset_p(reset_p), .btn_mode(btn_mode), .btn(btn),
        .seg_7(seg_7), .com(com), .led_stopwatch(led_stopwatch),
        .led_cookstart(led_cookstart), .led_lap(led_lap), .led_alarm(led_alarm),
        .buzz(buzz)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic display_word_u word_of(input int hi, input int lo);
        display_word_u w;
        w.bcd.hi10 = 4'(hi / 10);
        w.bcd.hi1 = 4'(hi % 10);
        w.bcd.lo10 = 4'(lo / 10);
        w.bcd.lo1 = 4'(lo % 10);
        return w;
    endfunction

    function automatic int field_hi(input display_word_u w);
        return 10 * int'(w.bcd.hi10) + int'(w.bcd.hi1);
    endfunction

    function automatic int field_lo(input display_word_u w);
        return 10 * int'(w.bcd.lo10) + int'(w.bcd.lo1);
    endfunction

    function automatic step_t make_step(input int key, input int presses, input int wait_sec,
            input int kind, input display_word_u lo, input display_word_u hi,
            input logic [4:0] leds);
        step_t s;
        s.key = key;
        s.presses = presses;
        s.wait_sec = wait_sec;
        s.kind = kind;
        s.lo = lo;
        s.hi = hi;
        s.leds = leds;
        return s;
    endfunction

    // Active-low segments, a in bit 0, dp off
    function automatic logic [3:0] decode_seg(input logic [7:0] seg);
        case (seg)
            8'hc0: return 4'd0;
            8'hf9: return 4'd1;
            8'ha4: return 4'd2;
            8'hb0: return 4'd3;
            8'h99: return 4'd4;
            8'h92: return 4'd5;
            8'h82: return 4'd6;
            8'hf8: return 4'd7;
            8'h80: return 4'd8;
            8'h90: return 4'd9;
            default: return 4'hf;
        endcase
    endfunction

    task automatic set_button(input int key, input logic level);
        if (key == key_mode) begin
            btn_mode = level;
        end else begin
            btn[key] = level;
        end
    endtask

    task automatic press(input int key);
        int hold;
        hold = debounce_clks + 2 + int'($urandom % 32'd4);
        @(negedge clk);
        set_button(key, 1'b1);
        repeat (hold) @(negedge clk);
        set_button(key, 1'b0);
        repeat (8) @(negedge clk);
    endtask

    task automatic wait_seconds(input int n);
        for (int i = 0; i < n * sec_clks; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_alarm();
        int cycles;
        cycles = 0;
        while (!led_alarm && cycles < 4 * sec_clks) begin
            @(negedge clk);
            cycles++;
        end
        if (!led_alarm) begin
            timeouts++;
            $display("Cook timer alarm did not go off within 4 s, time %0t", $time);
        end
    endtask

    // --------------------------------------------------
    // Display capture
    // --------------------------------------------------
    task automatic read_frame(output display_word_u word, output logic ok);
        logic [3:0] seen;
        logic [3:0] value;
        int cycles;
        seen = '0;
        word = '0;
        cycles = 0;
        while (seen != 4'hf && cycles < frame_clks) begin
            @(negedge clk);
            cycles++;
            for (int i = 0; i < num_digits; i++) begin
                if (com == ~(4'b0001 << i)) begin
                    value = decode_seg(seg_7);
                    if (value == 4'hf) begin
                        value_errors++;
                        $display("[FAIL] %0t: unknown segment pattern %h on digit %0d",
                            $time, seg_7, i);
                    end
                    word.digit[i] = value;
                    seen[i] = 1'b1;
                end
            end
        end
        ok = (seen == 4'hf);
    endtask

    // Two matching frames in a row, so a tick mid-scan is not read
    task automatic read_display(output display_word_u word);
        display_word_u prev;
        display_word_u cur;
        logic ok;
        logic settled;
        int tries;
        settled = 1'b0;
        tries = 0;
        read_frame(prev, ok);
        while (!settled && tries < settle_frames) begin
            read_frame(cur, ok);
            settled = ok && (cur == prev);
            prev = cur;
            tries++;
        end
        word = prev;
        if (!settled) begin
            timeouts++;
            $display("Display gave no steady full frame in %0d scans, time %0t",
                settle_frames, $time);
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input display_word_u got, input display_word_u lo,
            input display_word_u hi, input string what);
        checks++;
        if (field_hi(got) < field_hi(lo) || field_hi(got) > field_hi(hi) ||
                field_lo(got) < field_lo(lo) || field_lo(got) > field_lo(hi)) begin
            value_errors++;
            $display("[FAIL] %0t: %s display %h, expected %h to %h",
                $time, what, got, lo, hi);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_leds(input logic [4:0] exp, input string what);
        check_bit(led_stopwatch, exp[4], {what, " led_stopwatch"});
        check_bit(led_cookstart, exp[3], {what, " led_cookstart"});
        check_bit(led_lap, exp[2], {what, " led_lap"});
        check_bit(led_alarm, exp[1], {what, " led_alarm"});
        check_bit(buzz, exp[0], {what, " buzz"});
    endtask

    task automatic run_step(input step_t s, input int n);
        display_word_u got;
        display_word_u again;
        display_word_u lo;
        string tag;
        tag = $sformatf("step %0d", n);
        for (int i = 0; i < s.presses; i++) begin
            press(s.key);
        end
        wait_seconds(s.wait_sec);
        case (s.kind)
            chk_leds: check_leds(s.leds, tag);
            chk_range, chk_mark: begin
                read_display(got);
                check_word(got, s.lo, s.hi, tag);
                check_leds(s.leds, tag);
                if (s.kind == chk_mark) begin
                    last_watch = got;
                end
            end
            chk_hold: begin
                read_display(got);
                wait_seconds(1);
                read_display(again);
                check_word(again, got, got, tag);
                check_bit(got != '0, 1'b1, {tag, " held count nonzero"});
                check_leds(s.leds, tag);
            end
            chk_alarm: begin
                wait_alarm();
                read_display(got);
                check_word(got, s.lo, s.hi, tag);
                check_leds(s.leds, tag);
            end
            chk_later: begin
                lo = word_of(field_hi(s.lo), field_lo(last_watch) + 1);
                read_display(got);
                check_word(got, lo, s.hi, tag);
                check_leds(s.leds, tag);
            end
            default: ;
        endcase
    endtask

    initial begin
        void'($urandom(32'hc82a));
        checks = 0;
        value_errors = 0;
        timeouts = 0;
        last_watch = '0;
        reset_p = 1'b1;
        btn_mode = 1'b0;
        btn = '0;

        steps[0] = make_step(key_none, 0, 0, chk_range, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[1] = make_step(0, 1, 0, chk_range, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[2] = make_step(1, 3, 0, chk_none, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[3] = make_step(2, 2, 0, chk_range, word_of(2, 3), word_of(2, 3), 5'b00000);
        steps[4] = make_step(0, 1, 2, chk_mark, word_of(2, 3), word_of(2, 6), 5'b00000);
        // Stopwatch
        steps[5] = make_step(key_mode, 1, 0, chk_range, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[6] = make_step(0, 1, 1, chk_leds, word_of(0, 0), word_of(0, 0), 5'b10000);
        steps[7] = make_step(0, 1, 0, chk_hold, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[8] = make_step(0, 1, 0, chk_leds, word_of(0, 0), word_of(0, 0), 5'b10000);
        steps[9] = make_step(1, 1, 0, chk_hold, word_of(0, 0), word_of(0, 0), 5'b10100);
        steps[10] = make_step(2, 1, 0, chk_range, word_of(0, 0), word_of(0, 0), 5'b00000);
        // Cook timer
        steps[11] = make_step(key_mode, 1, 0, chk_range, word_of(0, 0), word_of(0, 0), 5'b00000);
        steps[12] = make_step(1, 2, 0, chk_range, word_of(0, 2), word_of(0, 2), 5'b00000);
        steps[13] = make_step(0, 1, 0, chk_range, word_of(0, 0), word_of(0, 2), 5'b01000);
        steps[14] = make_step(key_none, 0, 0, chk_alarm, word_of(0, 2), word_of(0, 2), 5'b00011);
        steps[15] = make_step(4, 1, 0, chk_range, word_of(0, 2), word_of(0, 2), 5'b00000);
        // Back to the watch, still counting
        steps[16] = make_step(key_mode, 1, 0, chk_later, word_of(2, 0), word_of(2, 59), 5'b00000);

        repeat (5) @(negedge clk);
        reset_p = 1'b0;

        for (int n = 0; n < num_steps; n++) begin
            run_step(steps[n], n + 1);
        end

        $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* clock_module.f */
logic/clock_pkg.sv
logic/mode_if.sv
logic/time_base.sv
logic/button_pulse.sv
logic/mode_arbiter.sv
logic/watch_mode.sv
logic/stopwatch_mode.sv
logic/cook_timer_mode.sv
logic/fnd_scan.sv
logic/clock_module.sv
bench/clock_module_asserts.sv
bench/clock_module_tb.sv

/* logic/button_pulse.sv */
`timescale 1ns/100ps

module button_pulse #(
    parameter int debounce_clks = 1_000_000
) (
    input logic clk,
    input logic reset_p,
    input logic btn,
    output logic pulse
);
    localparam int cnt_w = (debounce_clks > 1) ? $clog2(debounce_clks) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_clks - 1);

    logic [1:0] sync;
    logic stable;
    logic [cnt_w-1:0] cnt;

    // Level must differ from the debounced state for the full window
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync <= 2'b00;
            stable <= 1'b0;
            cnt <= '0;
            pulse <= 1'b0;
        end else begin
            sync <= {sync[0], btn};
            pulse <= 1'b0;
            if (sync[1] == stable) begin
                cnt <= '0;
            end else if (cnt == cnt_last) begin
                cnt <= '0;
                stable <= sync[1];
                pulse <= sync[1];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/clock_module.sv */
`timescale 1ns/100ps

module clock_module #(
    parameter int debounce_clks = 1_000_000,
    parameter int clks_per_centi = 1_000_000,
    parameter int scan_clks = 100_000
) (
    input logic clk,
    input logic reset_p,
    input logic btn_mode,
    input logic [4:0] btn,
    output logic [7:0] seg_7,
    output logic [3:0] com,
    output logic led_stopwatch,
    output logic led_cookstart,
    output logic led_lap,
    output logic led_alarm,
    output logic buzz
);
    import clock_pkg::*;

    logic tick_centi;
    logic tick_sec;
    logic mode_pulse;
    logic alarm_off_pulse;
    logic [2:0] key_pulse;
    display_word_u disp_word;

    mode_if watch_bus ();
    mode_if stopwatch_bus ();
    mode_if cook_bus ();

    // --------------------------------------------------
    // Time base and buttons
    // --------------------------------------------------
    time_base #(.clks_per_centi(clks_per_centi)) time_base_i (
        .clk(clk), .reset_p(reset_p), .tick_centi(tick_centi), .tick_sec(tick_sec)
    );

    button_pulse #(.debounce_clks(debounce_clks)) mode_btn_i (
        .clk(clk), .reset_p(reset_p), .btn(btn_mode), .pulse(mode_pulse)
    );

    for (genvar i = 0; i < 3; i++) begin : g_key
        button_pulse #(.debounce_clks(debounce_clks)) key_btn_i (
            .clk(clk), .reset_p(reset_p), .btn(btn[i]), .pulse(key_pulse[i])
        );
    end

    // Alarm off bypasses the arbiter
    button_pulse #(.debounce_clks(debounce_clks)) alarm_btn_i (
        .clk(clk), .reset_p(reset_p), .btn(btn[4]), .pulse(alarm_off_pulse)
    );

    // --------------------------------------------------
    // Modes and display
    // --------------------------------------------------
    mode_arbiter arbiter_i (
        .clk(clk), .reset_p(reset_p), .mode_pulse(mode_pulse), .key_pulse(key_pulse),
        .watch(watch_bus), .stopwatch(stopwatch_bus), .cook(cook_bus),
        .disp_word(disp_word)
    );

    watch_mode watch_i (
        .clk(clk), .reset_p(reset_p), .tick_sec(tick_sec), .port(watch_bus)
    );

    stopwatch_mode stopwatch_i (
        .clk(clk), .reset_p(reset_p), .tick_centi(tick_centi), .port(stopwatch_bus),
        .led_start(led_stopwatch), .led_lap(led_lap)
    );

    cook_timer_mode cook_i (
        .clk(clk), .reset_p(reset_p), .tick_sec(tick_sec), .alarm_off(alarm_off_pulse),
        .port(cook_bus), .led_start(led_cookstart), .led_alarm(led_alarm), .buzz(buzz)
    );

    fnd_scan #(.scan_clks(scan_clks)) fnd_i (
        .clk(clk), .reset_p(reset_p), .value(disp_word), .com(com), .seg_7(seg_7)
    );

endmodule

/* logic/clock_pkg.sv */
package clock_pkg;

    // --------------------------------------------------
    // Display and mode constants
    // --------------------------------------------------
    localparam int num_digits = 4;
    localparam int num_modes = 3;

    localparam logic [1:0] mode_watch = 2'd0;
    localparam logic [1:0] mode_stopwatch = 2'd1;
    localparam logic [1:0] mode_cook = 2'd2;

    // mm:ss for watch and cook timer, ss.cc for the stopwatch
    typedef struct packed {
        logic [3:0] hi10;
        logic [3:0] hi1;
        logic [3:0] lo10;
        logic [3:0] lo1;
    } bcd_time_t;

    // Counters write by field, the scanner reads by digit
    typedef union packed {
        bcd_time_t bcd;
        logic [num_digits-1:0][3:0] digit;
    } display_word_u;

    // --------------------------------------------------
    // Helper functions
    // --------------------------------------------------

    // Active low, bit 0 is segment a, dp kept off
    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'h0: return 8'b1100_0000;
            4'h1: return 8'b1111_1001;
            4'h2: return 8'b1010_0100;
            4'h3: return 8'b1011_0000;
            4'h4: return 8'b1001_1001;
            4'h5: return 8'b1001_0010;
            4'h6: return 8'b1000_0010;
            4'h7: return 8'b1111_1000;
            4'h8: return 8'b1000_0000;
            4'h9: return 8'b1001_0000;
            4'ha: return 8'b1000_1000;
            4'hb: return 8'b1000_0011;
            4'hc: return 8'b1100_0110;
            4'hd: return 8'b1010_0001;
            4'he: return 8'b1000_0110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    function automatic logic [7:0] bcd_inc(input logic [7:0] bcd, input int modulus);
        int value;
        value = 10 * int'(bcd[7:4]) + int'(bcd[3:0]);
        if (value >= modulus - 1) begin
            return 8'h00;
        end
        if (bcd[3:0] == 4'd9) begin
            return {bcd[7:4] + 4'd1, 4'd0};
        end
        return {bcd[7:4], bcd[3:0] + 4'd1};
    endfunction

    // 00 wraps back to 59
    function automatic logic [7:0] bcd_dec(input logic [7:0] bcd);
        if (bcd == 8'h00) begin
            return 8'h59;
        end
        if (bcd[3:0] == 4'd0) begin
            return {bcd[7:4] - 4'd1, 4'd9};
        end
        return {bcd[7:4], bcd[3:0] - 4'd1};
    endfunction

endpackage

/* logic/cook_timer_mode.sv */
`timescale 1ns/100ps

module cook_timer_mode (
    input logic clk,
    input logic reset_p,
    input logic tick_sec,
    input logic alarm_off,
    mode_if.mode port,
    output logic led_start,
    output logic led_alarm,
    output logic buzz
);
    import clock_pkg::*;

    logic started;
    logic alarm;
    bcd_time_t set_t;
    bcd_time_t cur_t;

    // Set value, stepped by the two keys
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_t <= '0;
        end else begin
            if (port.key_b) begin
                {set_t.lo10, set_t.lo1} <= bcd_inc({set_t.lo10, set_t.lo1}, 60);
            end
            if (port.key_c) begin
                {set_t.hi10, set_t.hi1} <= bcd_inc({set_t.hi10, set_t.hi1}, 60);
            end
        end
    end

    // Down counter and alarm
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            started <= 1'b0;
            alarm <= 1'b0;
            cur_t <= '0;
        end else if (port.key_a) begin
            started <= ~started;
            alarm <= 1'b0;
            cur_t <= set_t;
        end else if (started && cur_t == '0) begin
            started <= 1'b0;
            alarm <= 1'b1;
        end else begin
            if (alarm_off) begin
                alarm <= 1'b0;
            end
            if (started && tick_sec) begin
                {cur_t.lo10, cur_t.lo1} <= bcd_dec({cur_t.lo10, cur_t.lo1});
                if ({cur_t.lo10, cur_t.lo1} == 8'h00) begin
                    {cur_t.hi10, cur_t.hi1} <= bcd_dec({cur_t.hi10, cur_t.hi1});
                end
            end
        end
    end

    assign led_start = started;
    assign led_alarm = alarm;
    assign buzz = alarm;

    always_comb begin
        port.word = '0;
        if (port.active) begin
            port.word.bcd = started ? cur_t : set_t;
        end
    end

endmodule

/* logic/fnd_scan.sv */
`timescale 1ns/100ps

module fnd_scan #(
    parameter int scan_clks = 100_000
) (
    input logic clk,
    input logic reset_p,
    input clock_pkg::display_word_u value,
    output logic [clock_pkg::num_digits-1:0] com,
    output logic [7:0] seg_7
);
    import clock_pkg::*;

    localparam int cnt_w = (scan_clks > 1) ? $clog2(scan_clks) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(scan_clks - 1);

    logic [cnt_w-1:0] scan_cnt;
    logic [$clog2(num_digits)-1:0] digit_idx;

    // Rightmost digit first
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == cnt_last) begin
            scan_cnt <= '0;
            if (digit_idx == $bits(digit_idx)'(num_digits - 1)) begin
                digit_idx <= '0;
            end else begin
                digit_idx <= digit_idx + 1'b1;
            end
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign com = ~(num_digits'(1) << digit_idx);
    assign seg_7 = seg_pattern(value.digit[digit_idx]);

endmodule

/* logic/mode_arbiter.sv */
`timescale 1ns/100ps

module mode_arbiter (
    input logic clk,
    input logic reset_p,
    input logic mode_pulse,
    input logic [2:0] key_pulse,
    mode_if.arb watch,
    mode_if.arb stopwatch,
    mode_if.arb cook,
    output clock_pkg::display_word_u disp_word
);
    import clock_pkg::*;

    logic [1:0] mode;

    // Ring counter, watch -> stopwatch -> cook -> watch
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= mode_watch;
        end else if (mode_pulse) begin
            if (mode == 2'(num_modes - 1)) begin
                mode <= mode_watch;
            end else begin
                mode <= mode + 2'd1;
            end
        end
    end

    assign watch.active = (mode == mode_watch);
    assign stopwatch.active = (mode == mode_stopwatch);
    assign cook.active = (mode == mode_cook);

    // Only the owner sees the function keys
    assign {watch.key_c, watch.key_b, watch.key_a} =
        watch.active ? key_pulse : 3'b000;
    assign {stopwatch.key_c, stopwatch.key_b, stopwatch.key_a} =
        stopwatch.active ? key_pulse : 3'b000;
    assign {cook.key_c, cook.key_b, cook.key_a} =
        cook.active ? key_pulse : 3'b000;

    // Inactive modes drive an all-zero word
    assign disp_word = display_word_u'(watch.word | stopwatch.word | cook.word);

endmodule

/* logic/mode_if.sv */
`timescale 1ns/100ps

interface mode_if;
    import clock_pkg::*;

    // Button pulses, already gated by the arbiter
    logic key_a;
    logic key_b;
    logic key_c;
    // High while the mode owns the display
    logic active;
    display_word_u word;

    modport arb (
        output key_a, key_b, key_c, active,
        input word
    );

    modport mode (
        input key_a, key_b, key_c, active,
        output word
    );

endinterface

/* logic/stopwatch_mode.sv */
`timescale 1ns/100ps

module stopwatch_mode (
    input logic clk,
    input logic reset_p,
    input logic tick_centi,
    mode_if.mode port,
    output logic led_start,
    output logic led_lap
);
    import clock_pkg::*;

    logic running;
    logic lap;
    bcd_time_t count_t;
    bcd_time_t lap_t;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
            lap <= 1'b0;
            count_t <= '0;
            lap_t <= '0;
        end else if (port.key_c) begin
            running <= 1'b0;
            lap <= 1'b0;
            count_t <= '0;
            lap_t <= '0;
        end else begin
            if (port.key_a) begin
                running <= ~running;
            end
            if (port.key_b) begin
                lap <= ~lap;
                lap_t <= count_t;
            end
            // Hundredths carry into seconds
            if (running && tick_centi) begin
                {count_t.lo10, count_t.lo1} <= bcd_inc({count_t.lo10, count_t.lo1}, 100);
                if ({count_t.lo10, count_t.lo1} == 8'h99) begin
                    {count_t.hi10, count_t.hi1} <= bcd_inc({count_t.hi10, count_t.hi1}, 60);
                end
            end
        end
    end

    assign led_start = running;
    assign led_lap = lap;

    always_comb begin
        port.word = '0;
        if (port.active) begin
            port.word.bcd = lap ? lap_t : count_t;
        end
    end

endmodule

/* logic/time_base.sv */
`timescale 1ns/100ps

module time_base #(
    parameter int clks_per_centi = 1_000_000
) (
    input logic clk,
    input logic reset_p,
    output logic tick_centi,
    output logic tick_sec
);
    localparam int cnt_w = (clks_per_centi > 1) ? $clog2(clks_per_centi) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_centi - 1);

    logic [cnt_w-1:0] clk_cnt;
    logic [6:0] centi_cnt;

    assign tick_centi = (clk_cnt == cnt_last);
    // Every hundredth centisecond tick
    assign tick_sec = tick_centi && (centi_cnt == 7'd99);

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            clk_cnt <= '0;
            centi_cnt <= '0;
        end else if (tick_centi) begin
            clk_cnt <= '0;
            centi_cnt <= tick_sec ? 7'd0 : centi_cnt + 7'd1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* logic/watch_mode.sv */
`timescale 1ns/100ps

module watch_mode (
    input logic clk,
    input logic reset_p,
    input logic tick_sec,
    mode_if.mode port
);
    import clock_pkg::*;

    logic set_mode;
    bcd_time_t watch_t;
    bcd_time_t set_t;

    // --------------------------------------------------
    // Set copy
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            set_mode <= 1'b0;
            set_t <= '0;
        end else if (port.key_a) begin
            set_mode <= ~set_mode;
            // Entering set mode picks up the running time
            if (!set_mode) begin
                set_t <= watch_t;
            end
        end else if (set_mode) begin
            // No carry between the two fields here
            if (port.key_b) begin
                {set_t.lo10, set_t.lo1} <= bcd_inc({set_t.lo10, set_t.lo1}, 60);
            end
            if (port.key_c) begin
                {set_t.hi10, set_t.hi1} <= bcd_inc({set_t.hi10, set_t.hi1}, 60);
            end
        end
    end

    // --------------------------------------------------
    // Running watch
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            watch_t <= '0;
        end else if (port.key_a && set_mode) begin
            watch_t <= set_t;
        end else if (tick_sec) begin
            {watch_t.lo10, watch_t.lo1} <= bcd_inc({watch_t.lo10, watch_t.lo1}, 60);
            if ({watch_t.lo10, watch_t.lo1} == 8'h59) begin
                {watch_t.hi10, watch_t.hi1} <= bcd_inc({watch_t.hi10, watch_t.hi1}, 60);
            end
        end
    end

    always_comb begin
        port.word = '0;
        if (port.active) begin
            port.word.bcd = set_mode ? set_t : watch_t;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f clock_module.f --top-module clock_module_tb \
        -Mdir "$build_dir" -o clock_module_sim; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/clock_module_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log_file"; then
    exit 1
fi

exit 0
